// ==== src/packet_gen_settings.svh ====
// Size settings for the packet generator, shared by the packages, interfaces and modules
// Include wherever a table, stream or counter width is needed
`ifndef PACKET_GEN_SETTINGS_SVH
`define PACKET_GEN_SETTINGS_SVH

// Flow table
`define NUM_FLOWS      16
`define FLOW_IDX_W     4
`define CFG_WORDS      4

// Data path
`define DATA_W         64
`define MIN_PKT_WORDS  8

// Counters
`define PKT_CNT_W      32
`define BYTE_CNT_W     40
`define FINITE_CNT_W   16

`endif

// ==== src/flow_pkg.sv ====
// Flow table entry layout, as a decoded struct and as a view of 32-bit config words
// Referenced by scoped name from the arbiter, the config writer and the assembler
`include "packet_gen_settings.svh"

package flow_pkg;

    // One flow entry, 128 bits, mac_da on top
    typedef struct packed {
        logic [47:0] mac_da;
        logic [47:0] mac_sa;
        logic [15:0] ether_type;
        logic [7:0]  pkt_words;
        logic [7:0]  payload_value;
    } flow_def_t;

    // Word 0 is the most significant lane and holds mac_da[47:16]
    typedef logic [0:`CFG_WORDS-1][31:0] flow_words_t;

    // Config side writes by word, packet side reads by field
    typedef union packed {
        flow_def_t   def;
        flow_words_t words;
    } flow_word_u;

endpackage

// ==== src/tx_pkg.sv ====
// Transmit side types: assembler states and counter widths
// Referenced by scoped name from the assembler, the counters and the top level
`include "packet_gen_settings.svh"

package tx_pkg;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        HEADER,
        MIXED,
        PAYLOAD,
        DONE
    } asm_state_t;

    typedef logic [`PKT_CNT_W-1:0]  pkt_cnt_t;
    typedef logic [`BYTE_CNT_W-1:0] byte_cnt_t;

endpackage

// ==== src/flow_mem_if.sv ====
// Access port into the flow table, one instance per table master
// Master holds req and its request fields until gnt; read data follows gnt by one cycle
`include "packet_gen_settings.svh"

interface flow_mem_if;

    logic                         req;
    logic                         we;
    logic [`FLOW_IDX_W-1:0]       addr;
    logic [$clog2(`CFG_WORDS)-1:0] word_sel;
    logic [31:0]                  wdata;
    logic                         gnt;
    logic                         rvalid;
    flow_pkg::flow_word_u         rdata;

    modport master  (output req, we, addr, word_sel, wdata, input gnt, rvalid, rdata);
    modport arbiter (input req, we, addr, word_sel, wdata, output gnt, rvalid, rdata);

endinterface

// ==== src/pkt_stream_if.sv ====
// Internal 64-bit packet stream, every beat full, tuser carries the flow index
`include "packet_gen_settings.svh"

interface pkt_stream_if;

    logic [`DATA_W-1:0]     tdata;
    logic                   tvalid;
    logic                   tready;
    logic                   tlast;
    logic [`FLOW_IDX_W-1:0] tuser;

    modport source  (output tdata, tvalid, tlast, tuser, input tready);
    modport monitor (input tdata, tvalid, tready, tlast, tuser);

endinterface

// ==== src/flow_table_arbiter.sv ====
// Single-port flow table RAM shared by the packet assembler and the config writer
// Generator port always wins; the config port is served in any cycle it is left free
`include "packet_gen_settings.svh"

module flow_table_arbiter (
    input  logic         packet_out,
    input  logic         rst,
    flow_mem_if.arbiter  cfg_mem,
    flow_mem_if.arbiter  gen_mem
);

    flow_pkg::flow_word_u ram [`NUM_FLOWS];
    flow_pkg::flow_word_u rd_word;

    logic                          cfg_gnt;
    logic                          gen_gnt;
    logic                          port_en;
    logic                          port_we;
    logic [`FLOW_IDX_W-1:0]        port_addr;
    logic [$clog2(`CFG_WORDS)-1:0] port_sel;
    logic [31:0]                   port_wdata;

    ////////////////////
    // Fixed priority grant

    assign gen_gnt     = gen_mem.req;
    assign cfg_gnt     = cfg_mem.req && !gen_mem.req;
    assign gen_mem.gnt = gen_gnt;
    assign cfg_mem.gnt = cfg_gnt;

    // Steer the winner onto the one RAM port
    assign port_en    = gen_gnt || cfg_gnt;
    assign port_we    = gen_gnt ? gen_mem.we       : cfg_mem.we;
    assign port_addr  = gen_gnt ? gen_mem.addr     : cfg_mem.addr;
    assign port_sel   = gen_gnt ? gen_mem.word_sel : cfg_mem.word_sel;
    assign port_wdata = gen_gnt ? gen_mem.wdata    : cfg_mem.wdata;

    ////////////////////
    // RAM port

    always_ff @(posedge packet_out) begin
        if (rst) begin
            for (int i = 0; i < `NUM_FLOWS; i++) begin
                ram[i] <= '0;
            end
            gen_mem.rvalid <= 1'b0;
            cfg_mem.rvalid <= 1'b0;
        end else begin
            // Only the selected 32-bit lane changes on a write
            if (port_en && port_we) begin
                ram[port_addr].words[port_sel] <= port_wdata;
            end
            gen_mem.rvalid <= gen_gnt && !gen_mem.we;
            cfg_mem.rvalid <= cfg_gnt && !cfg_mem.we;
        end
    end

    // Whole entry read, valid the cycle after gnt
    always_ff @(posedge packet_out) begin
        if (port_en && !port_we) begin
            rd_word <= ram[port_addr];
        end
    end

    assign gen_mem.rdata = rd_word;
    assign cfg_mem.rdata = rd_word;

endmodule

// ==== src/flow_config_writer.sv ====
// Holds one configuration word and writes it into its flow table lane when granted
// cfg_busy covers the time from the accepted cfg_write until the word is in the RAM
`include "packet_gen_settings.svh"

module flow_config_writer (
    input  logic                          packet_out,
    input  logic                          rst,
    input  logic                          cfg_write,
    input  logic [`FLOW_IDX_W-1:0]        cfg_flow,
    input  logic [$clog2(`CFG_WORDS)-1:0] cfg_word,
    input  logic [31:0]                   cfg_data,
    output logic                          cfg_busy,
    flow_mem_if.master                    mem
);

    logic                          pending;
    logic                          accept;
    logic [`FLOW_IDX_W-1:0]        flow_q;
    logic [$clog2(`CFG_WORDS)-1:0] word_q;
    logic [31:0]                   data_q;

    // New words only while nothing is waiting
    assign accept = cfg_write && !pending;

    always_ff @(posedge packet_out) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (mem.gnt) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge packet_out) begin
        if (accept) begin
            flow_q <= cfg_flow;
            word_q <= cfg_word;
            data_q <= cfg_data;
        end
    end

    assign cfg_busy     = pending;
    assign mem.req      = pending;
    assign mem.we       = 1'b1;
    assign mem.addr     = flow_q;
    assign mem.word_sel = word_q;
    assign mem.wdata    = data_q;

endmodule

// ==== src/packet_assembler.sv ====
// Walks the flow table from entry 0 to last_flow and sends one Ethernet packet per entry
// Header in beats 0 and 1, fill bytes after; length is max(pkt_words, MIN_PKT_WORDS)
`include "packet_gen_settings.svh"

module packet_assembler (
    input  logic                     packet_out,
    input  logic                     rst,
    input  logic                     transmit,
    input  logic                     finite_tx,
    input  logic [`FINITE_CNT_W-1:0] finite_count,
    input  logic [`FLOW_IDX_W-1:0]   last_flow,
    flow_mem_if.master               mem,
    pkt_stream_if.source             out
);

    tx_pkg::asm_state_t       state;
    flow_pkg::flow_def_t      flow;
    logic [`FLOW_IDX_W-1:0]   flow_idx;
    logic [`FLOW_IDX_W-1:0]   next_idx;
    logic [`FLOW_IDX_W-1:0]   last_flow_q;
    logic                     finite_q;
    logic [`FINITE_CNT_W-1:0] pkts_left;
    logic [7:0]               beat_cnt;
    logic [7:0]               pkt_len;
    logic                     fetch_sent;
    logic                     xfer;
    logic                     final_beat;

    assign xfer       = out.tvalid && out.tready;
    assign final_beat = (state == tx_pkg::PAYLOAD) && (beat_cnt == pkt_len - 8'd1);
    assign next_idx   = (flow_idx == last_flow_q) ? '0 : flow_idx + 1'b1;

    ////////////////////
    // Table read

    assign mem.req      = (state == tx_pkg::FETCH) && !fetch_sent;
    assign mem.we       = 1'b0;
    assign mem.addr     = flow_idx;
    assign mem.word_sel = '0;
    assign mem.wdata    = '0;

    ////////////////////
    // Control FSM

    always_ff @(posedge packet_out) begin
        if (rst) begin
            state       <= tx_pkg::IDLE;
            flow_idx    <= '0;
            last_flow_q <= '0;
            finite_q    <= 1'b0;
            pkts_left   <= '0;
            beat_cnt    <= '0;
            fetch_sent  <= 1'b0;
        end else begin
            case (state)
                tx_pkg::IDLE: begin
                    flow_idx    <= '0;
                    last_flow_q <= last_flow;
                    finite_q    <= finite_tx;
                    // A count of zero still sends one packet
                    pkts_left   <= (finite_count == '0) ? '0 : finite_count - 1'b1;
                    if (transmit) begin
                        state <= tx_pkg::FETCH;
                    end
                end
                tx_pkg::FETCH: begin
                    if (mem.gnt) begin
                        fetch_sent <= 1'b1;
                    end
                    if (mem.rvalid) begin
                        fetch_sent <= 1'b0;
                        beat_cnt   <= '0;
                        state      <= tx_pkg::HEADER;
                    end
                end
                tx_pkg::HEADER, tx_pkg::MIXED, tx_pkg::PAYLOAD: begin
                    if (xfer) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        if (state == tx_pkg::HEADER) begin
                            state <= tx_pkg::MIXED;
                        end else if (state == tx_pkg::MIXED) begin
                            state <= tx_pkg::PAYLOAD;
                        end else if (final_beat) begin
                            if (!transmit) begin
                                state <= tx_pkg::IDLE;
                            end else if (finite_q && pkts_left == '0) begin
                                state <= tx_pkg::DONE;
                            end else begin
                                if (finite_q) begin
                                    pkts_left <= pkts_left - 1'b1;
                                end
                                flow_idx <= next_idx;
                                state    <= tx_pkg::FETCH;
                            end
                        end
                    end
                end
                tx_pkg::DONE: begin
                    if (!transmit) begin
                        state <= tx_pkg::IDLE;
                    end
                end
                default: state <= tx_pkg::IDLE;
            endcase
        end
    end

    // Entry and padded length, captured when the read returns
    always_ff @(posedge packet_out) begin
        if (state == tx_pkg::FETCH && mem.rvalid) begin
            flow    <= mem.rdata.def;
            pkt_len <= (mem.rdata.def.pkt_words < 8'(`MIN_PKT_WORDS)) ?
                       8'(`MIN_PKT_WORDS) : mem.rdata.def.pkt_words;
        end
    end

    ////////////////////
    // Beat contents

    // Byte 0 of each beat in tdata[63:56]
    always_comb begin
        out.tvalid = (state == tx_pkg::HEADER) || (state == tx_pkg::MIXED) ||
                     (state == tx_pkg::PAYLOAD);
        case (state)
            tx_pkg::HEADER: out.tdata = {flow.mac_da, flow.mac_sa[47:32]};
            tx_pkg::MIXED:  out.tdata = {flow.mac_sa[31:0], flow.ether_type,
                                         {2{flow.payload_value}}};
            default:        out.tdata = {8{flow.payload_value}};
        endcase
    end

    assign out.tlast = final_beat;
    assign out.tuser = flow_idx;

endmodule

// ==== src/tx_counters.sv ====
// Aggregate packet and byte counters on the output stream, both saturating
// cnt_sample copies the counts out and restarts them from zero
`include "packet_gen_settings.svh"

module tx_counters (
    input  logic              packet_out,
    input  logic              rst,
    pkt_stream_if.monitor     stream,
    input  logic              cnt_sample,
    output logic              sample_valid,
    output tx_pkg::pkt_cnt_t  pkt_count,
    output tx_pkg::byte_cnt_t byte_count
);

    tx_pkg::pkt_cnt_t  pkt_acc;
    tx_pkg::pkt_cnt_t  pkt_next;
    tx_pkg::byte_cnt_t byte_acc;
    tx_pkg::byte_cnt_t byte_next;
    logic [`BYTE_CNT_W:0] byte_sum;
    logic              beat_xfer;
    logic              pkt_xfer;

    assign beat_xfer = stream.tvalid && stream.tready;
    assign pkt_xfer  = beat_xfer && stream.tlast;

    // Hold at all-ones instead of wrapping
    assign pkt_next  = (pkt_xfer && !(&pkt_acc)) ? pkt_acc + 1'b1 : pkt_acc;
    assign byte_sum  = {1'b0, byte_acc} + (`BYTE_CNT_W + 1)'(8);
    assign byte_next = !beat_xfer ? byte_acc :
                       byte_sum[`BYTE_CNT_W] ? '1 : byte_sum[`BYTE_CNT_W-1:0];

    always_ff @(posedge packet_out) begin
        if (rst) begin
            pkt_acc      <= '0;
            byte_acc     <= '0;
            pkt_count    <= '0;
            byte_count   <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= cnt_sample;
            if (cnt_sample) begin
                pkt_count  <= pkt_acc;
                byte_count <= byte_acc;
                // A beat on the sample clock opens the new period
                pkt_acc    <= pkt_xfer ? tx_pkg::pkt_cnt_t'(1) : '0;
                byte_acc   <= beat_xfer ? tx_pkg::byte_cnt_t'(8) : '0;
            end else begin
                pkt_acc  <= pkt_next;
                byte_acc <= byte_next;
            end
        end
    end

endmodule

// ==== src/packet_gen_top.sv ====
// Flow-based Ethernet test packet generator with a 64-bit output stream
// Configuration, transmit control, stream and counters all appear as plain ports
`include "packet_gen_settings.svh"

module packet_gen_top (
    input  logic                          rst,
    input  logic                          packet_out,
    input  logic                          cfg_write,
    input  logic [`FLOW_IDX_W-1:0]        cfg_flow,
    input  logic [$clog2(`CFG_WORDS)-1:0] cfg_word,
    input  logic [31:0]                   cfg_data,
    output logic                          cfg_busy,
    input  logic                          transmit,
    input  logic                          finite_tx,
    input  logic [`FINITE_CNT_W-1:0]      finite_count,
    input  logic [`FLOW_IDX_W-1:0]        last_flow,
    output logic [`DATA_W-1:0]            tdata,
    output logic                          tvalid,
    input  logic                          tready,
    output logic                          tlast,
    output logic [`FLOW_IDX_W-1:0]        tuser,
    input  logic                          cnt_sample,
    output logic                          sample_valid,
    output tx_pkg::pkt_cnt_t              pkt_count,
    output tx_pkg::byte_cnt_t             byte_count
);

    flow_mem_if   cfg_mem ();
    flow_mem_if   gen_mem ();
    pkt_stream_if stream ();

    assign stream.tready = tready;
    assign tdata         = stream.tdata;
    assign tvalid        = stream.tvalid;
    assign tlast         = stream.tlast;
    assign tuser         = stream.tuser;

    flow_config_writer u_cfg_writer (
        .packet_out (packet_out),
        .rst        (rst),
        .cfg_write  (cfg_write),
        .cfg_flow   (cfg_flow),
        .cfg_word   (cfg_word),
        .cfg_data   (cfg_data),
        .cfg_busy   (cfg_busy),
        .mem        (cfg_mem.master)
    );

    flow_table_arbiter u_arbiter (
        .packet_out (packet_out),
        .rst        (rst),
        .cfg_mem    (cfg_mem.arbiter),
        .gen_mem    (gen_mem.arbiter)
    );

    packet_assembler u_assembler (
        .packet_out   (packet_out),
        .rst          (rst),
        .transmit     (transmit),
        .finite_tx    (finite_tx),
        .finite_count (finite_count),
        .last_flow    (last_flow),
        .mem          (gen_mem.master),
        .out          (stream.source)
    );

    tx_counters u_counters (
        .packet_out   (packet_out),
        .rst          (rst),
        .stream       (stream.monitor),
        .cnt_sample   (cnt_sample),
        .sample_valid (sample_valid),
        .pkt_count    (pkt_count),
        .byte_count   (byte_count)
    );

endmodule

// ==== bench/packet_gen_tb.sv ====
// Random-stimulus testbench that checks the packet generator beat by beat against a flow model
// Compile with the project file list; the top module is packet_gen_tb
`include "packet_gen_settings.svh"

module packet_gen_tb;

    logic                     packet_out;
    logic                     rst;
    logic                     cfg_write;
    logic [`FLOW_IDX_W-1:0]   cfg_flow;
    logic [1:0]               cfg_word;
    logic [31:0]              cfg_data;
    logic                     cfg_busy;
    logic                     transmit;
    logic                     finite_tx;
    logic [`FINITE_CNT_W-1:0] finite_count;
    logic [`FLOW_IDX_W-1:0]   last_flow;
    logic [`DATA_W-1:0]       tdata;
    logic                     tvalid;
    logic                     tready;
    logic                     tlast;
    logic [`FLOW_IDX_W-1:0]   tuser;
    logic                     cnt_sample;
    logic                     sample_valid;
    tx_pkg::pkt_cnt_t         pkt_count;
    tx_pkg::byte_cnt_t        byte_count;

    // Reference model of the flow table and the expected stream
    flow_pkg::flow_def_t    table_model [`NUM_FLOWS];
    logic [`DATA_W-1:0]     exp_data [$];
    logic                   exp_last [$];
    logic [`FLOW_IDX_W-1:0] exp_user [$];
    logic [127:0]           entry_bits;
    logic [31:0]            rand_state = 32'hddb2;
    logic [`FLOW_IDX_W-1:0] fin_last_flow;
    int                     fin_n;
    int error_count = 0;
    int n_checks = 0;
    int n_tests = 0;
    int n_failed = 0;
    int test_errors_start = 0;
    int total_pkts = 0;
    int total_beats = 0;
    int plan_beats = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    packet_gen_top uut (
        .rst (rst), .packet_out (packet_out),
        .cfg_write (cfg_write), .cfg_flow (cfg_flow), .cfg_word (cfg_word),
        .cfg_data (cfg_data), .cfg_busy (cfg_busy),
        .transmit (transmit), .finite_tx (finite_tx), .finite_count (finite_count),
        .last_flow (last_flow),
        .tdata (tdata), .tvalid (tvalid), .tready (tready), .tlast (tlast), .tuser (tuser),
        .cnt_sample (cnt_sample), .sample_valid (sample_valid),
        .pkt_count (pkt_count), .byte_count (byte_count)
    );

    always #10 packet_out = ~packet_out;

    // Watchdog
    always @(posedge packet_out) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////
    // Helpers

    // Upper half of a 32-bit LCG since the low bits cycle too fast
    function automatic logic [15:0] rand_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state[31:16];
    endfunction

    function automatic int padded_len(input logic [7:0] words);
        return (words < `MIN_PKT_WORDS) ? `MIN_PKT_WORDS : int'(words);
    endfunction

    function automatic int stream_beats(input int lf, input int n_pkts);
        int f;
        int total;
        f = 0;
        total = 0;
        for (int p = 0; p < n_pkts; p++) begin
            total += padded_len(table_model[f].pkt_words);
            f = (f == lf) ? 0 : f + 1;
        end
        return total;
    endfunction

    task automatic tick();
        @(posedge packet_out);
        #2;
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic check_beat(input logic [`DATA_W-1:0] e_data, input logic e_last,
                              input logic [`FLOW_IDX_W-1:0] e_user);
        n_checks++;
        if (tdata !== e_data) begin
            error_count++;
            $display("Mismatch at %0t: tdata expected %h, got %h", $time, e_data, tdata);
        end
        if (tlast !== e_last) begin
            error_count++;
            $display("Mismatch at %0t: tlast expected %b, got %b", $time, e_last, tlast);
        end
        if (tuser !== e_user) begin
            error_count++;
            $display("Mismatch at %0t: tuser expected %0d, got %0d", $time, e_user, tuser);
        end
    endtask

    task automatic check_count(input tx_pkg::pkt_cnt_t e_pkt, input tx_pkg::byte_cnt_t e_byte);
        n_checks++;
        if (pkt_count !== e_pkt) begin
            error_count++;
            $display("Mismatch at %0t: pkt_count expected %0d, got %0d", $time, e_pkt, pkt_count);
        end
        if (byte_count !== e_byte) begin
            error_count++;
            $display("Mismatch at %0t: byte_count expected %0d, got %0d",
                     $time, e_byte, byte_count);
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (error_count != test_errors_start) begin
            n_failed++;
            $display("Test %0d %s: FAILED, %0d errors", n_tests, name,
                     error_count - test_errors_start);
        end else begin
            $display("Test %0d %s: ok", n_tests, name);
        end
        test_errors_start = error_count;
    endtask

    ////////////////////
    // Stimulus

    task automatic write_word(input logic [`FLOW_IDX_W-1:0] flow, input logic [1:0] word,
                              input logic [31:0] data);
        cfg_write = 1'b1;
        cfg_flow  = flow;
        cfg_word  = word;
        cfg_data  = data;
        tick();
        cfg_write = 1'b0;
        if (!cfg_busy)
            report_error("cfg_busy did not rise after cfg_write");
        while (cfg_busy)
            tick();
    endtask

    // Expected beats for n_pkts packets from entry 0 with a wrap after lf
    task automatic expect_packets(input int lf, input int n_pkts);
        int f;
        int len;
        flow_pkg::flow_def_t d;
        f = 0;
        for (int p = 0; p < n_pkts; p++) begin
            d   = table_model[f];
            len = padded_len(d.pkt_words);
            for (int b = 0; b < len; b++) begin
                if (b == 0)
                    exp_data.push_back({d.mac_da, d.mac_sa[47:32]});
                else if (b == 1)
                    exp_data.push_back({d.mac_sa[31:0], d.ether_type,
                                        d.payload_value, d.payload_value});
                else
                    exp_data.push_back({8{d.payload_value}});
                exp_last.push_back(b == len - 1);
                exp_user.push_back(f[`FLOW_IDX_W-1:0]);
            end
            f = (f == lf) ? 0 : f + 1;
        end
    endtask

    task automatic run_stream(input logic [`FLOW_IDX_W-1:0] lf, input int n_pkts,
                              input logic fin, input logic [`FINITE_CNT_W-1:0] fcount,
                              input logic rand_ready);
        int pkts_seen;
        int quiet;
        logic held;
        logic drop_tx;
        logic stray;
        logic e_last;
        logic [`DATA_W-1:0] held_data;
        logic held_last;
        logic [`FLOW_IDX_W-1:0] held_user;
        logic [15:0] r;
        pkts_seen = 0;
        held      = 1'b0;
        drop_tx   = 1'b0;
        expect_packets(int'(lf), n_pkts);
        total_pkts  += n_pkts;
        total_beats += exp_data.size();
        last_flow    = lf;
        finite_tx    = fin;
        finite_count = fcount;
        transmit     = 1'b1;
        tready       = 1'b1;
        while (pkts_seen < n_pkts) begin
            @(negedge packet_out);
            // A stalled beat must come back unchanged
            if (held) begin
                if (!tvalid)
                    report_error("tvalid dropped before a stalled beat transferred");
                else
                    check_beat(held_data, held_last, held_user);
            end
            held = 1'b0;
            if (tvalid && tready) begin
                e_last = exp_last.pop_front();
                check_beat(exp_data.pop_front(), e_last, exp_user.pop_front());
                // Lower transmit inside the final packet so it ends there
                if (!fin && pkts_seen == n_pkts - 1)
                    drop_tx = 1'b1;
                if (e_last)
                    pkts_seen++;
            end else if (tvalid) begin
                held      = 1'b1;
                held_data = tdata;
                held_last = tlast;
                held_user = tuser;
            end
            tick();
            if (drop_tx)
                transmit = 1'b0;
            if (rand_ready) begin
                r      = rand_next();
                tready = r[15];
            end
        end
        tready = 1'b1;
        quiet  = fin ? 200 : 20;
        for (int i = 0; i < quiet; i++) begin
            @(negedge packet_out);
            stray = tvalid;
            tick();
            if (stray) begin
                report_error("tvalid rose after the last expected packet");
                break;
            end
        end
        transmit = 1'b0;
        repeat (3) tick();
    endtask

    task automatic sample_counts(input tx_pkg::pkt_cnt_t e_pkt, input tx_pkg::byte_cnt_t e_byte);
        cnt_sample = 1'b1;
        tick();
        cnt_sample = 1'b0;
        while (!sample_valid)
            tick();
        check_count(e_pkt, e_byte);
        tick();
    endtask

    ////////////////////
    // Test sequence

    initial begin
        packet_out   = 1'b0;
        rst          = 1'b1;
        cfg_write    = 1'b0;
        cfg_flow     = '0;
        cfg_word     = '0;
        cfg_data     = '0;
        transmit     = 1'b0;
        finite_tx    = 1'b0;
        finite_count = '0;
        last_flow    = '0;
        tready       = 1'b1;
        cnt_sample   = 1'b0;

        // Random table contents and test sizes fixed before the run
        for (int f = 0; f < `NUM_FLOWS; f++) begin
            table_model[f].mac_da        = {rand_next(), rand_next(), rand_next()};
            table_model[f].mac_sa        = {rand_next(), rand_next(), rand_next()};
            table_model[f].ether_type    = rand_next();
            table_model[f].pkt_words     = 8'(rand_next() % 16'd13);
            table_model[f].payload_value = 8'(rand_next());
        end
        // Entry 0 kept short so test 1 shows the padding
        table_model[0].pkt_words = 8'(rand_next() % 16'd8);
        fin_last_flow = (`FLOW_IDX_W)'(rand_next());
        fin_n         = int'(rand_next() % 16'd5);
        plan_beats = stream_beats(0, 4) + stream_beats(5, 9) + stream_beats(15, 18) +
                     stream_beats(int'(fin_last_flow), (fin_n == 0) ? 1 : fin_n);
        cycle_limit = 4 * plan_beats + 2000;

        repeat (8) tick();
        rst = 1'b0;

        if (tvalid || tlast || cfg_busy || sample_valid)
            report_error("an output was high after reset");
        check_count('0, '0);
        end_test("reset state");

        for (int f = 0; f < `NUM_FLOWS; f++) begin
            entry_bits = table_model[f];
            for (int w = 0; w < `CFG_WORDS; w++)
                write_word(f[`FLOW_IDX_W-1:0], w[1:0], entry_bits[127 - 32 * w -: 32]);
        end
        end_test("flow table configuration");

        run_stream(0, 4, 1'b0, '0, 1'b0);
        end_test("continuous, last_flow 0");
        run_stream(5, 9, 1'b0, '0, 1'b0);
        end_test("continuous, wrap after flow 5");
        run_stream(fin_last_flow, (fin_n == 0) ? 1 : fin_n, 1'b1,
                   (`FINITE_CNT_W)'(fin_n), 1'b0);
        end_test("finite packet count");
        run_stream(15, 18, 1'b0, '0, 1'b1);
        end_test("random back-pressure");

        sample_counts(tx_pkg::pkt_cnt_t'(total_pkts), tx_pkg::byte_cnt_t'(total_beats * 8));
        repeat (20) tick();
        sample_counts('0, '0);
        end_test("counter sample and clear");

        $display("Tests: %0d run, %0d failed; checks: %0d; errors: %0d",
                 n_tests, n_failed, n_checks, error_count);
        if (error_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== packet_gen.f ====
+incdir+src
src/flow_pkg.sv
src/tx_pkg.sv
src/flow_mem_if.sv
src/pkt_stream_if.sv
src/flow_table_arbiter.sv
src/flow_config_writer.sv
src/packet_assembler.sv
src/tx_counters.sv
src/packet_gen_top.sv
bench/packet_gen_tb.sv
